/* snd_pkg.sv */
package snd_pkg;

    // Sample and converter code widths
    localparam int PCM_W = 16;
    localparam int DAC_W = 20;

    // Register byte offsets on the 4-bit AXI4-Lite address
    localparam logic [3:0] REG_CTRL  = 4'h0;
    localparam logic [3:0] REG_DIV   = 4'h4;
    localparam logic [3:0] REG_COUNT = 4'h8;
    localparam logic [3:0] REG_LAST  = 4'hC;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // One PCM word, read either as two's complement or as offset binary
    typedef union packed {
        logic signed [PCM_W-1:0] pcm_signed;
        logic        [PCM_W-1:0] pcm_offset;
    } snd_sample_u;

    // Captured stereo frame
    typedef struct packed {
        snd_sample_u left;
        snd_sample_u right;
    } snd_frame_t;

    // CTRL register layout, enable in bit 3 down to mute in bit 0
    typedef struct packed {
        logic enable;
        logic signed_fmt;
        logic stereo;
        logic mute;
    } snd_ctrl_t;

endpackage

/* snd_ctrl.sv */
`timescale 1ns/1ps

module snd_ctrl #(
    parameter int DIV_W = 8
) (
    input  logic                clk_dac,
    input  logic                rst,
    // AXI4-Lite write channels
    input  logic [3:0]          s_awaddr_i,
    input  logic                s_awvalid_i,
    output logic                s_awready_o,
    input  logic [31:0]         s_wdata_i,
    input  logic [3:0]          s_wstrb_i,
    input  logic                s_wvalid_i,
    output logic                s_wready_o,
    output logic [1:0]          s_bresp_o,
    output logic                s_bvalid_o,
    input  logic                s_bready_i,
    // AXI4-Lite read channels
    input  logic [3:0]          s_araddr_i,
    input  logic                s_arvalid_i,
    output logic                s_arready_o,
    output logic [31:0]         s_rdata_o,
    output logic [1:0]          s_rresp_o,
    output logic                s_rvalid_o,
    input  logic                s_rready_i,
    // Game samples
    input  logic [15:0]         snd_left_i,
    input  logic [15:0]         snd_right_i,
    input  logic                snd_sample_i,
    // To the datapath
    output snd_pkg::snd_ctrl_t  ctrl_o,
    output snd_pkg::snd_frame_t frame_o,
    output logic                cen_o
);

    localparam snd_pkg::snd_ctrl_t CTRL_RST = '{
        enable:     1'b0,
        signed_fmt: 1'b1,
        stereo:     1'b1,
        mute:       1'b0
    };

    snd_pkg::snd_ctrl_t  ctrl_q;
    snd_pkg::snd_frame_t frame_q;
    logic [DIV_W-1:0]    div_q;
    logic [DIV_W-1:0]    cen_cnt;
    logic                cen_q;
    logic [31:0]         count_q;
    logic                awready_q;
    logic                bvalid_q;
    logic [1:0]          bresp_q;
    logic                rvalid_q;
    logic [31:0]         rdata_q;
    logic [1:0]          rresp_q;
    logic                wr_fire;
    logic                ar_fire;
    logic [31:0]         ctrl_new;
    logic [31:0]         div_new;
    logic [31:0]         rd_data;
    logic [1:0]          rd_resp;

    // Byte lanes not strobed keep their old value
    function automatic logic [31:0] merge_strb(
        input logic [31:0] old_w,
        input logic [31:0] new_w,
        input logic [3:0]  strb
    );
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign wr_fire  = awready_q & s_awvalid_i & s_wvalid_i;
    assign ar_fire  = s_arvalid_i & ~rvalid_q;
    assign ctrl_new = merge_strb({28'd0, ctrl_q}, s_wdata_i, s_wstrb_i);
    assign div_new  = merge_strb(32'(div_q), s_wdata_i, s_wstrb_i);

    // Address and data accepted together, one cycle of ready
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            awready_q <= 1'b0;
            bvalid_q  <= 1'b0;
            bresp_q   <= snd_pkg::RESP_OKAY;
            ctrl_q    <= CTRL_RST;
            div_q     <= DIV_W'(3);
        end else begin
            awready_q <= s_awvalid_i & s_wvalid_i & ~bvalid_q & ~awready_q;
            if (wr_fire) begin
                bvalid_q <= 1'b1;
                bresp_q  <= snd_pkg::RESP_OKAY;
                case (s_awaddr_i)
                    snd_pkg::REG_CTRL: ctrl_q <= snd_pkg::snd_ctrl_t'(ctrl_new[3:0]);
                    snd_pkg::REG_DIV:  div_q  <= div_new[DIV_W-1:0];
                    // COUNT, LAST and holes
                    default:           bresp_q <= snd_pkg::RESP_SLVERR;
                endcase
            end else if (s_bready_i) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_data = '0;
        rd_resp = snd_pkg::RESP_OKAY;
        case (s_araddr_i)
            snd_pkg::REG_CTRL:  rd_data[3:0]       = ctrl_q;
            snd_pkg::REG_DIV:   rd_data[DIV_W-1:0] = div_q;
            snd_pkg::REG_COUNT: rd_data            = count_q;
            snd_pkg::REG_LAST:  rd_data            = {frame_q.left, frame_q.right};
            default:            rd_resp            = snd_pkg::RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            rvalid_q <= 1'b0;
            rdata_q  <= '0;
            rresp_q  <= snd_pkg::RESP_OKAY;
        end else if (ar_fire) begin
            rvalid_q <= 1'b1;
            rdata_q  <= rd_data;
            rresp_q  <= rd_resp;
        end else if (s_rready_i) begin
            rvalid_q <= 1'b0;
        end
    end

    // Enable pulse every DIV+1 clocks, new DIV picked up on reload
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            cen_cnt <= DIV_W'(3);
            cen_q   <= 1'b0;
        end else if (cen_cnt == '0) begin
            cen_cnt <= div_q;
            cen_q   <= 1'b1;
        end else begin
            cen_cnt <= cen_cnt - 1'b1;
            cen_q   <= 1'b0;
        end
    end

    // Frame capture, newest strobe wins
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            frame_q <= '0;
            count_q <= '0;
        end else if (snd_sample_i && ctrl_q.enable) begin
            frame_q <= {snd_left_i, snd_right_i};
            count_q <= count_q + 32'd1;
        end
    end

    assign s_awready_o = awready_q;
    assign s_wready_o  = awready_q;
    assign s_bvalid_o  = bvalid_q;
    assign s_bresp_o   = bresp_q;
    assign s_arready_o = ~rvalid_q;
    assign s_rvalid_o  = rvalid_q;
    assign s_rdata_o   = rdata_q;
    assign s_rresp_o   = rresp_q;
    assign ctrl_o      = ctrl_q;
    assign frame_o     = frame_q;
    assign cen_o       = cen_q;

endmodule

/* snd_fmt.sv */
`timescale 1ns/1ps

module snd_fmt (
    input  logic                      clk_dac,
    input  logic                      rst,
    input  snd_pkg::snd_ctrl_t        ctrl_i,
    input  snd_pkg::snd_frame_t       frame_i,
    output logic [snd_pkg::DAC_W-1:0] code_l_o,
    output logic [snd_pkg::DAC_W-1:0] code_r_o
);

    localparam int PAD_W = snd_pkg::DAC_W - snd_pkg::PCM_W - 1;

    // Top bit alone gives a density of one half
    localparam logic [snd_pkg::DAC_W-1:0] SILENT_CODE = {1'b1, {(snd_pkg::DAC_W-1){1'b0}}};

    // Guard bit, sample as offset binary, then zero padding
    function automatic logic [snd_pkg::DAC_W-1:0] to_code(
        input snd_pkg::snd_sample_u smp,
        input logic                 signed_fmt
    );
        logic [snd_pkg::PCM_W-1:0] ofs;
        if (signed_fmt) begin
            ofs = {~smp.pcm_signed[snd_pkg::PCM_W-1], smp.pcm_signed[snd_pkg::PCM_W-2:0]};
        end else begin
            ofs = smp.pcm_offset;
        end
        return {1'b0, ofs, {PAD_W{1'b0}}};
    endfunction

    snd_pkg::snd_sample_u src_r;
    logic                 silent;

    // Mono plays the left sample on both pins
    assign src_r  = ctrl_i.stereo ? frame_i.right : frame_i.left;
    assign silent = ctrl_i.mute | ~ctrl_i.enable;

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            code_l_o <= SILENT_CODE;
            code_r_o <= SILENT_CODE;
        end else if (silent) begin
            code_l_o <= SILENT_CODE;
            code_r_o <= SILENT_CODE;
        end else begin
            code_l_o <= to_code(frame_i.left, ctrl_i.signed_fmt);
            code_r_o <= to_code(src_r, ctrl_i.signed_fmt);
        end
    end

endmodule

/* snd_sd_dac.sv */
`timescale 1ns/1ps

module snd_sd_dac (
    input  logic                      clk_dac,
    input  logic                      rst,
    input  logic                      cen_i,
    input  logic [snd_pkg::DAC_W-1:0] code_i,
    output logic                      dac_o
);

    logic [snd_pkg::DAC_W-1:0] acc_q;
    logic [snd_pkg::DAC_W:0]   sum;
    logic                      dac_q;

    // One extra bit holds the carry
    assign sum = {1'b0, acc_q} + {1'b0, code_i};

    // First-order loop, the carry is the output pulse
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            acc_q <= '0;
            dac_q <= 1'b0;
        end else if (cen_i) begin
            acc_q <= sum[snd_pkg::DAC_W-1:0];
            dac_q <= sum[snd_pkg::DAC_W];
        end
    end

    assign dac_o = dac_q;

endmodule

/* snd_out_top.sv */
`timescale 1ns/1ps

module snd_out_top #(
    parameter int DIV_W = 8
) (
    input  logic        clk_dac,
    input  logic        rst,
    // AXI4-Lite slave
    input  logic [3:0]  s_awaddr_i,
    input  logic        s_awvalid_i,
    output logic        s_awready_o,
    input  logic [31:0] s_wdata_i,
    input  logic [3:0]  s_wstrb_i,
    input  logic        s_wvalid_i,
    output logic        s_wready_o,
    output logic [1:0]  s_bresp_o,
    output logic        s_bvalid_o,
    input  logic        s_bready_i,
    input  logic [3:0]  s_araddr_i,
    input  logic        s_arvalid_i,
    output logic        s_arready_o,
    output logic [31:0] s_rdata_o,
    output logic [1:0]  s_rresp_o,
    output logic        s_rvalid_o,
    input  logic        s_rready_i,
    // Game sound
    input  logic [15:0] snd_left_i,
    input  logic [15:0] snd_right_i,
    input  logic        snd_sample_i,
    // Pulse-density pins
    output logic        snd_pwm_left_o,
    output logic        snd_pwm_right_o
);

    snd_pkg::snd_ctrl_t        ctrl;
    snd_pkg::snd_frame_t       frame;
    logic                      cen;
    logic [snd_pkg::DAC_W-1:0] code_l;
    logic [snd_pkg::DAC_W-1:0] code_r;

    snd_ctrl #(
        .DIV_W (DIV_W)
    ) u_ctrl (
        .clk_dac      (clk_dac),
        .rst          (rst),
        .s_awaddr_i   (s_awaddr_i),
        .s_awvalid_i  (s_awvalid_i),
        .s_awready_o  (s_awready_o),
        .s_wdata_i    (s_wdata_i),
        .s_wstrb_i    (s_wstrb_i),
        .s_wvalid_i   (s_wvalid_i),
        .s_wready_o   (s_wready_o),
        .s_bresp_o    (s_bresp_o),
        .s_bvalid_o   (s_bvalid_o),
        .s_bready_i   (s_bready_i),
        .s_araddr_i   (s_araddr_i),
        .s_arvalid_i  (s_arvalid_i),
        .s_arready_o  (s_arready_o),
        .s_rdata_o    (s_rdata_o),
        .s_rresp_o    (s_rresp_o),
        .s_rvalid_o   (s_rvalid_o),
        .s_rready_i   (s_rready_i),
        .snd_left_i   (snd_left_i),
        .snd_right_i  (snd_right_i),
        .snd_sample_i (snd_sample_i),
        .ctrl_o       (ctrl),
        .frame_o      (frame),
        .cen_o        (cen)
    );

    snd_fmt u_fmt (
        .clk_dac  (clk_dac),
        .rst      (rst),
        .ctrl_i   (ctrl),
        .frame_i  (frame),
        .code_l_o (code_l),
        .code_r_o (code_r)
    );

    snd_sd_dac u_dac_left (
        .clk_dac (clk_dac),
        .rst     (rst),
        .cen_i   (cen),
        .code_i  (code_l),
        .dac_o   (snd_pwm_left_o)
    );

    snd_sd_dac u_dac_right (
        .clk_dac (clk_dac),
        .rst     (rst),
        .cen_i   (cen),
        .code_i  (code_r),
        .dac_o   (snd_pwm_right_o)
    );

endmodule

/* tb_snd_check.sv */
`timescale 1ns/1ps

module tb_snd_check #(
    parameter int DIV_W = 8
) (
    input  logic        clk_dac,
    input  logic        rst,
    input  logic [3:0]  awaddr_i,
    input  logic        awvalid_i,
    input  logic        awready_i,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  wstrb_i,
    input  logic        wvalid_i,
    input  logic [15:0] left_i,
    input  logic [15:0] right_i,
    input  logic        sample_i,
    input  logic        pin_l_i,
    input  logic        pin_r_i,
    output int          err_o,
    output logic [31:0] count_o,
    output logic [31:0] last_o,
    output logic [31:0] en_cnt_o,
    output logic [31:0] dut_ones_l_o,
    output logic [31:0] dut_ones_r_o,
    output logic [31:0] mdl_ones_l_o,
    output logic [31:0] mdl_ones_r_o
);

    localparam logic [19:0] SILENT = 20'h80000;

    // Model CTRL bits: enable, signed_fmt, stereo, mute
    logic [3:0]       ctrl_m;
    logic [DIV_W-1:0] div_m;
    logic [DIV_W-1:0] cnt_m;
    logic             cen_m;
    logic             upd_m;
    logic [19:0]      code_l_m;
    logic [19:0]      code_r_m;
    logic [19:0]      acc_l_m;
    logic [19:0]      acc_r_m;
    logic             dac_l_m;
    logic             dac_r_m;
    logic             pin_l_q;
    logic             pin_r_q;
    logic             wr_fire;

    // Guard bit, offset-binary sample, three zero bits
    function automatic logic [19:0] code_of(input logic [15:0] smp, input logic signed_fmt);
        logic [15:0] ofs;
        ofs = signed_fmt ? (smp ^ 16'h8000) : smp;
        return {1'b0, ofs, 3'b000};
    endfunction

    function automatic logic [DIV_W-1:0] div_merge(input logic [DIV_W-1:0] old_v);
        logic [DIV_W-1:0] v;
        v = old_v;
        for (int b = 0; b < DIV_W; b++) begin
            if (wstrb_i[b / 8]) begin
                v[b] = wdata_i[b];
            end
        end
        return v;
    endfunction

    assign wr_fire = awready_i & awvalid_i & wvalid_i;

    always @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            ctrl_m   <= 4'h6;
            div_m    <= DIV_W'(3);
            cnt_m    <= DIV_W'(3);
            cen_m    <= 1'b0;
            upd_m    <= 1'b0;
            count_o  <= '0;
            last_o   <= '0;
            code_l_m <= SILENT;
            code_r_m <= SILENT;
            acc_l_m  <= '0;
            acc_r_m  <= '0;
            dac_l_m  <= 1'b0;
            dac_r_m  <= 1'b0;
        end else begin
            if (wr_fire && awaddr_i == 4'h0 && wstrb_i[0]) begin
                ctrl_m <= wdata_i[3:0];
            end
            if (wr_fire && awaddr_i == 4'h4) begin
                div_m <= div_merge(div_m);
            end
            if (cnt_m == '0) begin
                cnt_m <= div_m;
                cen_m <= 1'b1;
            end else begin
                cnt_m <= cnt_m - 1'b1;
                cen_m <= 1'b0;
            end
            if (sample_i && ctrl_m[3]) begin
                last_o  <= {left_i, right_i};
                count_o <= count_o + 32'd1;
            end
            // Mute or disabled plays midscale
            if (ctrl_m[0] || !ctrl_m[3]) begin
                code_l_m <= SILENT;
                code_r_m <= SILENT;
            end else begin
                code_l_m <= code_of(last_o[31:16], ctrl_m[2]);
                code_r_m <= code_of(ctrl_m[1] ? last_o[15:0] : last_o[31:16], ctrl_m[2]);
            end
            upd_m <= cen_m;
            if (cen_m) begin
                {dac_l_m, acc_l_m} <= {1'b0, acc_l_m} + {1'b0, code_l_m};
                {dac_r_m, acc_r_m} <= {1'b0, acc_r_m} + {1'b0, code_r_m};
            end
        end
    end

    // Pins are stable around the falling edge
    always @(negedge clk_dac) begin
        if (rst) begin
            err_o        = 0;
            en_cnt_o     <= '0;
            dut_ones_l_o <= '0;
            dut_ones_r_o <= '0;
            mdl_ones_l_o <= '0;
            mdl_ones_r_o <= '0;
        end else begin
            assert (pin_l_i === dac_l_m) else begin
                $display("FAIL snd_pwm_left_o: got %h, expected %h", pin_l_i, dac_l_m);
                err_o++;
            end
            assert (pin_r_i === dac_r_m) else begin
                $display("FAIL snd_pwm_right_o: got %h, expected %h", pin_r_i, dac_r_m);
                err_o++;
            end
            assert (upd_m || (pin_l_i === pin_l_q && pin_r_i === pin_r_q)) else begin
                $display("A pin changed on a cycle without a converter enable");
                err_o++;
            end
            if (upd_m) begin
                en_cnt_o     <= en_cnt_o + 32'd1;
                dut_ones_l_o <= dut_ones_l_o + {31'd0, pin_l_i};
                dut_ones_r_o <= dut_ones_r_o + {31'd0, pin_r_i};
                mdl_ones_l_o <= mdl_ones_l_o + {31'd0, dac_l_m};
                mdl_ones_r_o <= mdl_ones_r_o + {31'd0, dac_r_m};
            end
        end
        pin_l_q = pin_l_i;
        pin_r_q = pin_r_i;
    end

endmodule

/* tb_snd_out.sv */
`timescale 1ns/1ps

module tb_snd_out;

    localparam int DIV_W  = 8;
    localparam int CLK_NS = 100;
    // Cycle budget of each test phase
    localparam int REG_CYC  = 300;
    localparam int MONO_CYC = 250;
    localparam int CAP_CYC  = 300;
    localparam int CEN_CYC  = 1100;
    localparam int CONV_CYC = 16500;
    localparam int MUTE_CYC = 600;
    localparam int TEST_CYC = REG_CYC + MONO_CYC + CAP_CYC + CEN_CYC + CONV_CYC + MUTE_CYC;

    logic        clk_dac;
    logic        rst;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [15:0] left;
    logic [15:0] right;
    logic        sample;
    logic        pwm_l;
    logic        pwm_r;
    int          top_err = 0;
    int          chk_err;
    logic [31:0] count_m;
    logic [31:0] last_m;
    logic [31:0] en_cnt;
    logic [31:0] dut_ones_l;
    logic [31:0] dut_ones_r;
    logic [31:0] mdl_ones_l;
    logic [31:0] mdl_ones_r;
    logic [31:0] lfsr = 32'h5708_1255;

    snd_out_top #(
        .DIV_W (DIV_W)
    ) dut_i (
        .clk_dac         (clk_dac),
        .rst             (rst),
        .s_awaddr_i      (awaddr),
        .s_awvalid_i     (awvalid),
        .s_awready_o     (awready),
        .s_wdata_i       (wdata),
        .s_wstrb_i       (wstrb),
        .s_wvalid_i      (wvalid),
        .s_wready_o      (wready),
        .s_bresp_o       (bresp),
        .s_bvalid_o      (bvalid),
        .s_bready_i      (bready),
        .s_araddr_i      (araddr),
        .s_arvalid_i     (arvalid),
        .s_arready_o     (arready),
        .s_rdata_o       (rdata),
        .s_rresp_o       (rresp),
        .s_rvalid_o      (rvalid),
        .s_rready_i      (rready),
        .snd_left_i      (left),
        .snd_right_i     (right),
        .snd_sample_i    (sample),
        .snd_pwm_left_o  (pwm_l),
        .snd_pwm_right_o (pwm_r)
    );

    tb_snd_check #(
        .DIV_W (DIV_W)
    ) u_check (
        .clk_dac      (clk_dac),
        .rst          (rst),
        .awaddr_i     (awaddr),
        .awvalid_i    (awvalid),
        .awready_i    (awready),
        .wdata_i      (wdata),
        .wstrb_i      (wstrb),
        .wvalid_i     (wvalid),
        .left_i       (left),
        .right_i      (right),
        .sample_i     (sample),
        .pin_l_i      (pwm_l),
        .pin_r_i      (pwm_r),
        .err_o        (chk_err),
        .count_o      (count_m),
        .last_o       (last_m),
        .en_cnt_o     (en_cnt),
        .dut_ones_l_o (dut_ones_l),
        .dut_ones_r_o (dut_ones_r),
        .mdl_ones_l_o (mdl_ones_l),
        .mdl_ones_r_o (mdl_ones_r)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic check_write(input logic [3:0] addr, input logic [31:0] data,
                               input logic [3:0] strb, input logic [1:0] exp_resp);
        @(posedge clk_dac);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        do @(negedge clk_dac); while (!awready);
        assert (wready) else begin
            $display("FAIL s_wready_o: got %h, expected %h", wready, 1'b1);
            top_err++;
        end
        @(posedge clk_dac);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(negedge clk_dac); while (!bvalid);
        assert (bresp == exp_resp) else begin
            $display("FAIL s_bresp_o: addr %h got %h, expected %h", addr, bresp, exp_resp);
            top_err++;
        end
    endtask

    task automatic check_read(input logic [3:0] addr, input logic [31:0] exp_data,
                              input logic [1:0] exp_resp);
        @(posedge clk_dac);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(negedge clk_dac); while (!arready);
        @(posedge clk_dac);
        arvalid <= 1'b0;
        do @(negedge clk_dac); while (!rvalid);
        assert (rdata == exp_data) else begin
            $display("FAIL s_rdata_o: addr %h got %h, expected %h", addr, rdata, exp_data);
            top_err++;
        end
        assert (rresp == exp_resp) else begin
            $display("FAIL s_rresp_o: addr %h got %h, expected %h", addr, rresp, exp_resp);
            top_err++;
        end
    endtask

    task automatic drive_sample(input logic strobe);
        @(posedge clk_dac);
        sample <= strobe;
        left   <= 16'(rand_bits(16));
        right  <= 16'(rand_bits(16));
    endtask

    task automatic stop_samples();
        @(posedge clk_dac);
        sample <= 1'b0;
        @(negedge clk_dac);
    endtask

    task automatic wait_enables(input int n);
        logic [31:0] target;
        target = en_cnt + 32'(n);
        while (en_cnt < target) @(negedge clk_dac);
    endtask

    // Ones on both pins over n enables against the model and optionally against n/2
    task automatic compare_ones(input int n, input logic half);
        logic [31:0] b_dl;
        logic [31:0] b_dr;
        logic [31:0] b_ml;
        logic [31:0] b_mr;
        @(negedge clk_dac);
        b_dl = dut_ones_l;
        b_dr = dut_ones_r;
        b_ml = mdl_ones_l;
        b_mr = mdl_ones_r;
        wait_enables(n);
        assert (dut_ones_l - b_dl == mdl_ones_l - b_ml) else begin
            $display("FAIL snd_pwm_left_o ones: got %h, expected %h",
                     dut_ones_l - b_dl, mdl_ones_l - b_ml);
            top_err++;
        end
        assert (dut_ones_r - b_dr == mdl_ones_r - b_mr) else begin
            $display("FAIL snd_pwm_right_o ones: got %h, expected %h",
                     dut_ones_r - b_dr, mdl_ones_r - b_mr);
            top_err++;
        end
        if (half) begin
            assert (dut_ones_l - b_dl == 32'(n / 2) && dut_ones_r - b_dr == 32'(n / 2)) else begin
                $display("FAIL snd_pwm_left_o/snd_pwm_right_o ones: got %h %h, expected %h",
                         dut_ones_l - b_dl, dut_ones_r - b_dr, n / 2);
                top_err++;
            end
        end
    endtask

    initial begin
        clk_dac = 1'b0;
        forever #(CLK_NS / 2) clk_dac = ~clk_dac;
    end

    initial begin
        #(TEST_CYC * 2 * CLK_NS);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic [31:0] d;
        logic [3:0]  s;
        logic [3:0]  ctrl_v;
        logic [7:0]  div_v;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        left    = '0;
        right   = '0;
        sample  = 1'b0;
        rst     = 1'b1;
        repeat (2) @(posedge clk_dac);
        rst <= 1'b0;

        // Reset values
        check_read(4'h0, 32'h6, 2'b00);
        check_read(4'h4, 32'h3, 2'b00);
        check_read(4'h8, 32'h0, 2'b00);
        check_read(4'hC, 32'h0, 2'b00);

        // Writable registers with random byte strobes
        ctrl_v = 4'h6;
        div_v  = 8'h3;
        repeat (6) begin
            d = rand_bits(32);
            s = 4'(rand_bits(4));
            check_write(4'h0, d, s, 2'b00);
            if (s[0]) ctrl_v = d[3:0];
            check_read(4'h0, {28'd0, ctrl_v}, 2'b00);
            d = rand_bits(32);
            s = 4'(rand_bits(4));
            check_write(4'h4, d, s, 2'b00);
            if (s[0]) div_v = d[7:0];
            check_read(4'h4, {24'd0, div_v}, 2'b00);
        end

        // Read-only and unmapped addresses
        check_write(4'h8, rand_bits(32), 4'hF, 2'b10);
        check_write(4'hC, rand_bits(32), 4'hF, 2'b10);
        check_write(4'h2, rand_bits(32), 4'hF, 2'b10);
        check_read(4'h6, 32'h0, 2'b10);
        check_read(4'h8, 32'h0, 2'b00);
        check_read(4'hC, 32'h0, 2'b00);
        check_read(4'h0, {28'd0, ctrl_v}, 2'b00);

        // Mono while both accumulators are still equal since no frame differed yet
        check_write(4'h4, 32'd1, 4'hF, 2'b00);
        check_write(4'h0, 32'hC, 4'hF, 2'b00);
        repeat (200) begin
            drive_sample(rand_bits(1) != 0);
            @(negedge clk_dac);
            assert (pwm_r == pwm_l) else begin
                $display("FAIL snd_pwm_right_o: got %h, expected %h", pwm_r, pwm_l);
                top_err++;
            end
        end
        stop_samples();

        // Capture with one pass where enable is clear
        for (int k = 0; k < 4; k++) begin
            check_write(4'h0, {28'd0, k != 1, 3'b110}, 4'hF, 2'b00);
            repeat (50) drive_sample(rand_bits(1) != 0);
            stop_samples();
            check_read(4'h8, count_m, 2'b00);
            check_read(4'hC, last_m, 2'b00);
        end

        // Clock enable spacing
        repeat (4) begin
            check_write(4'h4, rand_bits(3), 4'hF, 2'b00);
            wait_enables(32);
        end

        // Conversion in signed and then offset binary
        for (int f = 0; f < 2; f++) begin
            check_write(4'h0, {28'd0, 1'b1, f == 0, 2'b10}, 4'hF, 2'b00);
            repeat (2) begin
                check_write(4'h4, rand_bits(2), 4'hF, 2'b00);
                drive_sample(1'b1);
                stop_samples();
                compare_ones(1024, 1'b0);
            end
        end

        // Mute and then enable clear
        check_write(4'h0, 32'hF, 4'hF, 2'b00);
        wait_enables(4);
        compare_ones(64, 1'b1);
        check_write(4'h0, 32'h6, 4'hF, 2'b00);
        wait_enables(4);
        compare_ones(64, 1'b1);

        $display("Errors: %0d in bus and count checks, %0d in model checks", top_err, chk_err);
        if (top_err + chk_err == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
snd_pkg.sv
snd_ctrl.sv
snd_fmt.sv
snd_sd_dac.sv
snd_out_top.sv
tb_snd_check.sv
tb_snd_out.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the sound output testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_snd_out -f tb.f -o tb_snd_out
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_snd_out)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
